/* verilog/dacfifo_config.svh */
// ==========================================================================
// Shared sizes for the DAC playback read path. Include this file wherever
// a width, the buffer depth, a threshold or the DDR base address is needed.
// ==========================================================================

`ifndef DACFIFO_CONFIG_SVH
`define DACFIFO_CONFIG_SVH

// Avalon memory word and DAC sample widths
`define DACFIFO_AVL_DATA_WIDTH 128
`define DACFIFO_DAC_DATA_WIDTH 32

// Number of DAC samples packed in one Avalon word
`define DACFIFO_MEM_RATIO 4

// Buffer pointer widths, 16 words or 64 samples
`define DACFIFO_AVL_MEM_ADDR_WIDTH 4
`define DACFIFO_DAC_MEM_ADDR_WIDTH 6

// Refill hysteresis in words
`define DACFIFO_THRESHOLD_LO 4
`define DACFIFO_THRESHOLD_HI 12

// DDR side word addressing
`define DACFIFO_AVL_ADDR_WIDTH 25
`define DACFIFO_DDR_BASE_ADDRESS 0

`endif

/* verilog/dacfifo_pkg.sv */
// ==========================================================================
// Types shared by the DAC playback read path: the memory word view, the
// Avalon command and response bundles and the buffer write bundle.
// ==========================================================================

`include "dacfifo_config.svh"

package dacfifo_pkg;

  typedef logic [`DACFIFO_DAC_DATA_WIDTH-1:0] dac_sample_t;

  // One DDR word is either a flat Avalon data word or a row of DAC samples.
  // Sample 0 sits in the least significant bits and plays first
  typedef union packed {
    logic [`DACFIFO_AVL_DATA_WIDTH-1:0]        raw;
    dac_sample_t [`DACFIFO_MEM_RATIO-1:0]      samples;
  } avl_word_u;

  // ========================================================================
  // Avalon-MM read master signals
  // ========================================================================

  typedef struct packed {
    logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]        address;
    logic [5:0]                                burstcount;
    logic [`DACFIFO_AVL_DATA_WIDTH/8-1:0]      byteenable;
    logic                                      read;
  } avl_cmd_t;

  typedef struct packed {
    logic                                      ready;
    logic                                      readdatavalid;
    avl_word_u                                 data;
  } avl_rsp_t;

  // Returned word on its way into the sample buffer
  typedef struct packed {
    logic                                      wr_en;
    avl_word_u                                 data;
  } buf_wr_t;

endpackage

/* verilog/dacfifo_rd_ctrl.sv */
// ==========================================================================
// Control for the playback read path. Starts and stops sessions, runs the
// refill hysteresis and turns DAC strobes into buffer reads or underflows.
// ==========================================================================

`timescale 1ns/1ps

`include "dacfifo_config.svh"

module dacfifo_rd_ctrl (
  input  logic                                  avl_clk,
  input  logic                                  avl_reset,
  input  logic                                  avl_xfer_req,
  input  logic [`DACFIFO_AVL_MEM_ADDR_WIDTH:0]  word_level,
  input  logic [`DACFIFO_DAC_MEM_ADDR_WIDTH:0]  sample_level,
  input  logic                                  dac_valid,
  output logic                                  fetch_en,
  output logic                                  restart,
  output logic                                  clear,
  output logic                                  rd_en,
  output logic                                  dac_xfer_req,
  output logic                                  dac_dunf
);

  localparam int WORD_LEVEL_WIDTH = `DACFIFO_AVL_MEM_ADDR_WIDTH + 1;

  localparam logic [WORD_LEVEL_WIDTH-1:0] LEVEL_LO = WORD_LEVEL_WIDTH'(`DACFIFO_THRESHOLD_LO);
  localparam logic [WORD_LEVEL_WIDTH-1:0] LEVEL_HI = WORD_LEVEL_WIDTH'(`DACFIFO_THRESHOLD_HI);

  logic xfer_req_d;
  logic xfer_req_dd;
  logic samples_avail;
  logic strobe;

  // ========================================================================
  // Session start and refill
  // ========================================================================

  // The rising edge of the host request becomes a one cycle restart pulse,
  // two cycles after the edge itself
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      xfer_req_d  <= 1'b0;
      xfer_req_dd <= 1'b0;
      restart     <= 1'b0;
    end else begin
      xfer_req_d  <= avl_xfer_req;
      xfer_req_dd <= xfer_req_d;
      restart     <= xfer_req_d & ~xfer_req_dd;
    end
  end

  // Refill stops at the high mark and resumes at the low mark. Outside a
  // session nothing new is fetched, so the register is forced low
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      fetch_en <= 1'b0;
    end else if (!xfer_req_dd) begin
      fetch_en <= 1'b0;
    end else if (word_level >= LEVEL_HI) begin
      fetch_en <= 1'b0;
    end else if (word_level <= LEVEL_LO) begin
      fetch_en <= 1'b1;
    end
  end

  // The buffer is flushed at a restart and kept empty between sessions,
  // which drops any word still landing after the drain
  assign clear = restart | (~avl_xfer_req & ~dac_xfer_req);

  // ========================================================================
  // DAC side transfer state
  // ========================================================================

  assign samples_avail = (sample_level != '0);
  assign strobe        = dac_valid & dac_xfer_req;

  // Playback begins once data is buffered and ends only after the buffer
  // has drained completely
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      dac_xfer_req <= 1'b0;
    end else if (avl_xfer_req && samples_avail) begin
      dac_xfer_req <= 1'b1;
    end else if (!avl_xfer_req && !samples_avail) begin
      dac_xfer_req <= 1'b0;
    end
  end

  // A strobe either takes a sample or is reported as underflow on the
  // following cycle. The DAC cannot be held off
  assign rd_en = strobe & samples_avail;

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      dac_dunf <= 1'b0;
    end else begin
      dac_dunf <= strobe & ~samples_avail;
    end
  end

endmodule

/* verilog/dacfifo_avl_master.sv */
// ==========================================================================
// Avalon-MM read master. Walks the sample set one word at a time from the
// DDR base to the last address, wraps, and forwards each word to the buffer.
// ==========================================================================

`timescale 1ns/1ps

`include "dacfifo_config.svh"

module dacfifo_avl_master (
  input  logic                                avl_clk,
  input  logic                                avl_reset,
  input  logic                                fetch_en,
  input  logic                                restart,
  input  logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]  avl_last_address,
  output dacfifo_pkg::avl_cmd_t               avl_cmd,
  input  dacfifo_pkg::avl_rsp_t               avl_rsp,
  output dacfifo_pkg::buf_wr_t                buf_wr
);

  localparam logic [`DACFIFO_AVL_ADDR_WIDTH-1:0] BASE_ADDRESS =
    `DACFIFO_AVL_ADDR_WIDTH'(`DACFIFO_DDR_BASE_ADDRESS);

  logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]  address;
  logic                                read;
  logic                                outstanding;
  logic                                stale;
  logic                                accept;
  logic                                rsp_done;
  logic                                drop;
  logic                                wr_en;
  logic [`DACFIFO_AVL_DATA_WIDTH-1:0]  wr_data;

  assign accept   = read & avl_rsp.ready;
  assign rsp_done = outstanding & avl_rsp.readdatavalid;

  // A word requested before a restart belongs to the old session
  assign drop = stale | restart;

  // ========================================================================
  // Command issue and outstanding tracking
  // ========================================================================

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      read        <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      if (accept) begin
        read        <= 1'b0;
        outstanding <= 1'b1;
      end else if (!read && !outstanding && fetch_en && !restart) begin
        read <= 1'b1;
      end
      if (rsp_done) begin
        outstanding <= 1'b0;
      end
    end
  end

  // The address stays put while a command waits for ready or a word is in
  // flight. A restart in that window is remembered and applied on return
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      address <= BASE_ADDRESS;
      stale   <= 1'b0;
    end else begin
      if (rsp_done) begin
        stale <= 1'b0;
      end else if (restart && (read || outstanding)) begin
        stale <= 1'b1;
      end
      if (rsp_done) begin
        if (drop || (address == avl_last_address)) begin
          address <= BASE_ADDRESS;
        end else begin
          address <= address + 1'b1;
        end
      end else if (restart && !read && !outstanding) begin
        address <= BASE_ADDRESS;
      end
    end
  end

  // Single word reads with every byte lane enabled
  always_comb begin
    avl_cmd.address    = address;
    avl_cmd.burstcount = 6'd1;
    avl_cmd.byteenable = '1;
    avl_cmd.read       = read;
  end

  // ========================================================================
  // Returned data
  // ========================================================================

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= rsp_done & ~drop;
    end
  end

  always_ff @(posedge avl_clk) begin
    if (rsp_done) begin
      wr_data <= avl_rsp.data.raw;
    end
  end

  always_comb begin
    buf_wr.wr_en    = wr_en;
    buf_wr.data.raw = wr_data;
  end

endmodule

/* verilog/dacfifo_sample_buf.sv */
// ==========================================================================
// Asymmetric sample buffer. Written one Avalon word at a time and read one
// DAC sample at a time, it also reports its fill level to the control block.
// ==========================================================================

`timescale 1ns/1ps

`include "dacfifo_config.svh"

module dacfifo_sample_buf (
  input  logic                                  avl_clk,
  input  logic                                  avl_reset,
  input  dacfifo_pkg::buf_wr_t                  buf_wr,
  input  logic                                  clear,
  input  logic                                  rd_en,
  input  logic                                  dac_xfer_req,
  output logic [`DACFIFO_AVL_MEM_ADDR_WIDTH:0]  word_level,
  output logic [`DACFIFO_DAC_MEM_ADDR_WIDTH:0]  sample_level,
  output logic [`DACFIFO_DAC_DATA_WIDTH-1:0]    dac_data
);

  import dacfifo_pkg::*;

  localparam int WORD_AW    = `DACFIFO_AVL_MEM_ADDR_WIDTH;
  localparam int SAMPLE_AW  = `DACFIFO_DAC_MEM_ADDR_WIDTH;
  localparam int RATIO_BITS = SAMPLE_AW - WORD_AW;
  localparam int DEPTH      = 1 << WORD_AW;

  avl_word_u mem [DEPTH];

  // Both pointers carry one extra bit so a full buffer differs from empty
  logic [WORD_AW:0]    wr_ptr;
  logic [SAMPLE_AW:0]  rd_ptr;
  logic [SAMPLE_AW:0]  rd_ptr_ceil;
  dac_sample_t         rd_sample;

  // ========================================================================
  // Storage and pointers
  // ========================================================================

  always_ff @(posedge avl_clk) begin
    if (buf_wr.wr_en && !clear) begin
      mem[wr_ptr[WORD_AW-1:0]] <= buf_wr.data;
    end
  end

  always_ff @(posedge avl_clk) begin
    if (avl_reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (buf_wr.wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Upper read pointer bits pick the word, the lower bits pick the sample
  assign rd_sample = mem[rd_ptr[SAMPLE_AW-1:RATIO_BITS]].samples[rd_ptr[RATIO_BITS-1:0]];

  // ========================================================================
  // Fill levels
  // ========================================================================

  // A partly played word still occupies its slot, so the read pointer is
  // rounded up to whole words before the difference
  assign rd_ptr_ceil  = rd_ptr + (SAMPLE_AW + 1)'(`DACFIFO_MEM_RATIO - 1);
  assign word_level   = wr_ptr - rd_ptr_ceil[SAMPLE_AW:RATIO_BITS];
  assign sample_level = {wr_ptr, {RATIO_BITS{1'b0}}} - rd_ptr;

  // ========================================================================
  // DAC output register
  // ========================================================================

  // The last sample is held through underflow strobes and idle cycles
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      dac_data <= '0;
    end else if (!dac_xfer_req) begin
      dac_data <= '0;
    end else if (rd_en) begin
      dac_data <= rd_sample;
    end
  end

endmodule

/* verilog/dacfifo_rd.sv */
// ==========================================================================
// DAC playback read path top level. Connects the control block, the Avalon
// read master and the sample buffer on the single avl_clk domain.
// ==========================================================================

`timescale 1ns/1ps

`include "dacfifo_config.svh"

module dacfifo_rd (
  input  logic                                avl_clk,
  input  logic                                avl_reset,
  input  logic                                avl_xfer_req,
  input  logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]  avl_last_address,
  output dacfifo_pkg::avl_cmd_t               avl_cmd,
  input  dacfifo_pkg::avl_rsp_t               avl_rsp,
  input  logic                                dac_valid,
  output logic [`DACFIFO_DAC_DATA_WIDTH-1:0]  dac_data,
  output logic                                dac_xfer_req,
  output logic                                dac_dunf
);

  import dacfifo_pkg::*;

  logic                                  fetch_en;
  logic                                  restart;
  logic                                  clear;
  logic                                  rd_en;
  logic [`DACFIFO_AVL_MEM_ADDR_WIDTH:0]  word_level;
  logic [`DACFIFO_DAC_MEM_ADDR_WIDTH:0]  sample_level;
  buf_wr_t                               buf_wr;

  dacfifo_rd_ctrl rd_ctrl_i (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .avl_xfer_req (avl_xfer_req),
    .word_level   (word_level),
    .sample_level (sample_level),
    .dac_valid    (dac_valid),
    .fetch_en     (fetch_en),
    .restart      (restart),
    .clear        (clear),
    .rd_en        (rd_en),
    .dac_xfer_req (dac_xfer_req),
    .dac_dunf     (dac_dunf)
  );

  dacfifo_avl_master avl_master_i (
    .avl_clk          (avl_clk),
    .avl_reset        (avl_reset),
    .fetch_en         (fetch_en),
    .restart          (restart),
    .avl_last_address (avl_last_address),
    .avl_cmd          (avl_cmd),
    .avl_rsp          (avl_rsp),
    .buf_wr           (buf_wr)
  );

  dacfifo_sample_buf sample_buf_i (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .buf_wr       (buf_wr),
    .clear        (clear),
    .rd_en        (rd_en),
    .dac_xfer_req (dac_xfer_req),
    .word_level   (word_level),
    .sample_level (sample_level),
    .dac_data     (dac_data)
  );

endmodule

/* dv/dacfifo_rd_chk.sv */
// ==========================================================================
// Bound assertions on the Avalon read protocol and the DAC output rules
// ==========================================================================

`timescale 1ns/1ps

module dacfifo_rd_chk (
  input logic                   avl_clk,
  input logic                   avl_reset,
  input dacfifo_pkg::avl_cmd_t  avl_cmd,
  input dacfifo_pkg::avl_rsp_t  avl_rsp,
  input logic                   dac_valid,
  input logic                   dac_xfer_req,
  input logic                   dac_dunf
);

  logic in_flight;

  // Tracks the single read that may be between accept and data return
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      in_flight <= 1'b0;
    end else if (avl_cmd.read && avl_rsp.ready) begin
      in_flight <= 1'b1;
    end else if (avl_rsp.readdatavalid) begin
      in_flight <= 1'b0;
    end
  end

  a_one_outstanding: assert property (@(posedge avl_clk) disable iff (avl_reset)
    avl_cmd.read |-> !in_flight)
    else $error("read issued while another read is outstanding");

  a_cmd_hold: assert property (@(posedge avl_clk) disable iff (avl_reset)
    (avl_cmd.read && !avl_rsp.ready) |=> (avl_cmd.read && $stable(avl_cmd.address)))
    else $error("read command changed while ready was low");

  a_cmd_format: assert property (@(posedge avl_clk) disable iff (avl_reset)
    avl_cmd.read |-> (avl_cmd.burstcount == 6'd1 && &avl_cmd.byteenable))
    else $error("burstcount or byteenable wrong on a read");

  a_reset_state: assert property (@(posedge avl_clk)
    avl_reset |=> (!avl_cmd.read && !dac_xfer_req && !dac_dunf))
    else $error("outputs not idle after reset");

  // Underflow only follows a strobe during a transfer
  a_dunf_cause: assert property (@(posedge avl_clk) disable iff (avl_reset)
    dac_dunf |-> $past(dac_valid && dac_xfer_req))
    else $error("dac_dunf without a preceding strobe");

endmodule

/* dv/dacfifo_rd_tb.sv */
// ==========================================================================
// Testbench for the playback read path. A DDR model with random latency
// feeds the DUT, random DAC strobes drain it and a scoreboard checks order.
// ==========================================================================

`timescale 1ns/1ps

`include "dacfifo_config.svh"

module dacfifo_rd_tb;

  import dacfifo_pkg::*;

  localparam int EXPECTED_STROBES = 1500;
  localparam int TIMEOUT_CYCLES   = 8 * EXPECTED_STROBES + 2000;
  localparam int RATIO            = `DACFIFO_MEM_RATIO;

  logic                                avl_clk;
  logic                                avl_reset;
  logic                                avl_xfer_req;
  logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]  avl_last_address;
  avl_cmd_t                            avl_cmd;
  avl_rsp_t                            avl_rsp;
  logic                                dac_valid;
  logic [`DACFIFO_DAC_DATA_WIDTH-1:0]  dac_data;
  logic                                dac_xfer_req;
  logic                                dac_dunf;

  // Model state, all updated on the falling edge
  int unsigned  cycle = 0;
  int unsigned  delivered = 0;
  int unsigned  ready_words = 0;
  int unsigned  dunf_seen = 0;
  int unsigned  rdv_cycles[$];
  bit           pending = 1'b0;
  int unsigned  pend_wait = 0;
  logic [`DACFIFO_AVL_ADDR_WIDTH-1:0] pend_addr;
  bit           xfer_want = 1'b0;
  bit           reset_want = 1'b1;
  int unsigned  density = 90;
  int unsigned  lat_min = 1;
  int unsigned  lat_max = 4;
  logic         dxr_pre = 1'b0;
  logic [31:0]  data_pre = '0;
  avl_cmd_t     cmd_pre = '0;
  int unsigned  watchdog = 0;
  int           err_count = 0;

  dacfifo_rd dacfifo_rd_i (
    .avl_clk          (avl_clk),
    .avl_reset        (avl_reset),
    .avl_xfer_req     (avl_xfer_req),
    .avl_last_address (avl_last_address),
    .avl_cmd          (avl_cmd),
    .avl_rsp          (avl_rsp),
    .dac_valid        (dac_valid),
    .dac_data         (dac_data),
    .dac_xfer_req     (dac_xfer_req),
    .dac_dunf         (dac_dunf)
  );

  bind dacfifo_rd dacfifo_rd_chk chk_i (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .avl_cmd      (avl_cmd),
    .avl_rsp      (avl_rsp),
    .dac_valid    (dac_valid),
    .dac_xfer_req (dac_xfer_req),
    .dac_dunf     (dac_dunf)
  );

  initial avl_clk = 1'b0;
  always #2 avl_clk = ~avl_clk;

  always @(posedge avl_clk) begin
    watchdog <= watchdog + 1;
    if (watchdog >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "Timeout");
    end
  end

  // ========================================================================
  // Reference model
  // ========================================================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Sample k of a session, counted from sample 0 of the base word
  function automatic logic [31:0] expected_sample(input int unsigned k);
    int unsigned span;
    int unsigned addr;
    int unsigned lane;
    span = 32'(avl_last_address) - `DACFIFO_DDR_BASE_ADDRESS + 1;
    addr = `DACFIFO_DDR_BASE_ADDRESS + (k / RATIO) % span;
    lane = k % RATIO;
    return {addr[15:0], lane[15:0]};
  endfunction

  function automatic avl_word_u ddr_word(input logic [`DACFIFO_AVL_ADDR_WIDTH-1:0] addr);
    avl_word_u w;
    for (int i = 0; i < RATIO; i++) begin
      w.samples[i] = {addr[15:0], 16'(i)};
    end
    return w;
  endfunction

  // One clock cycle: check what the last rising edge did, then drive inputs
  task automatic step();
    int   avail;
    logic dxr_exp;
    @(negedge avl_clk);
    cycle++;
    // A returned word can serve a strobe two edges after readdatavalid
    while (rdv_cycles.size() > 0 && rdv_cycles[0] + 2 <= cycle) begin
      void'(rdv_cycles.pop_front());
      ready_words++;
    end

    // Samples the buffer held at the last rising edge
    avail = int'(ready_words * RATIO) - int'(delivered);

    // Playback starts once data is buffered and ends only with the buffer empty
    if (avl_xfer_req && avail > 0) begin
      dxr_exp = 1'b1;
    end else if (!avl_xfer_req && avail == 0) begin
      dxr_exp = 1'b0;
    end else begin
      dxr_exp = dxr_pre;
    end
    check_value("dac_xfer_req", 32'(dac_xfer_req), 32'(dxr_exp));

    if (dac_valid && dxr_pre) begin
      if (avail > 0) begin
        check_value("dac_dunf", 32'(dac_dunf), 32'd0);
        check_value("dac_data", dac_data, expected_sample(delivered));
        delivered++;
      end else begin
        check_value("dac_dunf", 32'(dac_dunf), 32'd1);
        check_value("dac_data", dac_data, data_pre);
        dunf_seen++;
      end
    end else begin
      check_value("dac_dunf", 32'(dac_dunf), 32'd0);
      if (!dxr_pre) begin
        check_value("dac_data", dac_data, 32'd0);
      end else begin
        check_value("dac_data", dac_data, data_pre);
      end
    end

    // DDR model
    if (avl_rsp.readdatavalid) begin
      rdv_cycles.push_back(cycle);
    end
    if (cmd_pre.read && avl_rsp.ready) begin
      pending   = 1'b1;
      pend_addr = cmd_pre.address;
      pend_wait = $urandom_range(lat_max, lat_min);
    end
    avl_rsp.readdatavalid = 1'b0;
    if (pending) begin
      pend_wait--;
      if (pend_wait == 0) begin
        avl_rsp.readdatavalid = 1'b1;
        avl_rsp.data          = ddr_word(pend_addr);
        pending               = 1'b0;
      end
    end
    avl_rsp.ready = ($urandom_range(3) != 0);
    dac_valid     = ($urandom_range(99) < density);
    avl_xfer_req  = xfer_want;
    avl_reset     = reset_want;

    data_pre = dac_data;
    dxr_pre  = dac_xfer_req;
    cmd_pre  = avl_cmd;
  endtask

  // ========================================================================
  // Sessions
  // ========================================================================

  task automatic start_session();
    while (pending || avl_cmd.read || rdv_cycles.size() > 0) begin
      step();
    end
    delivered   = 0;
    ready_words = 0;
    xfer_want   = 1'b1;
    step();
  endtask

  task automatic stop_and_drain();
    xfer_want = 1'b0;
    step();
    while (dac_xfer_req) begin
      step();
    end
    check_value("samples left after drain", delivered, ready_words * RATIO);
    repeat (4) step();
    while (pending || avl_cmd.read) begin
      step();
    end
    repeat (10) step();
  endtask

  initial begin
    void'($urandom(32'h979));
    avl_reset        = 1'b1;
    avl_xfer_req     = 1'b0;
    avl_last_address = 25'd5;
    avl_rsp          = '0;
    dac_valid        = 1'b0;

    repeat (10) step();
    reset_want = 1'b0;
    repeat (5) step();

    // Playback across several wraps of a six word set
    start_session();
    while (delivered < 300) begin
      step();
    end

    // Slow memory with a strobe every cycle runs the buffer dry
    lat_min = 6;
    lat_max = 8;
    density = 100;
    while (delivered < 500 || dunf_seen < 10) begin
      step();
    end

    lat_min = 1;
    lat_max = 4;
    density = 80;
    repeat (100) step();
    stop_and_drain();

    // A new session begins again at the base word
    start_session();
    while (delivered < 100) begin
      step();
    end
    stop_and_drain();

    if (err_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Checks failed");
    end
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/dacfifo_pkg.sv
verilog/dacfifo_rd_ctrl.sv
verilog/dacfifo_avl_master.sv
verilog/dacfifo_sample_buf.sv
verilog/dacfifo_rd.sv
dv/dacfifo_rd_chk.sv
dv/dacfifo_rd_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the DAC playback read path testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module dacfifo_rd_tb -o dacfifo_rd_sim

output=$(./obj_dir/dacfifo_rd_sim || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
